//--- design/ex_pkg.sv
package ex_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  shamt_t;

  typedef enum logic [3:0] {
    ADD,
    SUB,
    OR,
    XOR,
    NOR,
    AND,
    PASS_A,
    PASS_B,
    LUI,
    MOVZ,
    MOVN,
    SEB,
    SEH,
    EXT,
    INS
  } alu_op_t;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_SHIFT,
    RES_SET
  } alu_res_t;

  typedef enum logic [2:0] {
    MD_NONE,
    MD_MUL,
    MD_MADD,
    MD_DIV,
    MD_MTHI,
    MD_MTLO,
    MD_MFHI,
    MD_MFLO
  } muldiv_op_t;

  typedef enum logic {
    MDU_IDLE,
    MDU_BUSY
  } mdu_state_t;

  // Decoded control for one instruction in execute
  typedef struct packed {
    alu_op_t    alu_op;
    alu_res_t   alu_res_sel;
    logic       alu_set_u;
    muldiv_op_t muldiv_op;
    logic       muldiv_u;
    logic       imm_valid;
    shamt_t     shamt;
    logic       shamt_valid;
    logic       shleft;
    logic       sharith;
    logic       shopsela;
  } ex_ctrl_t;

  // Pending register write of a later stage
  typedef struct packed {
    word_t    result;
    reg_idx_t dest;
    logic     dest_valid;
  } fwd_src_t;

endpackage

//--- design/operand_forward.sv
`timescale 1ns/1ps

module operand_forward (
  input  logic             clock,
  input  logic             reset_n,
  input  logic             stall_active,
  input  ex_pkg::word_t    a_val,
  input  ex_pkg::word_t    b_val,
  input  ex_pkg::reg_idx_t a_reg,
  input  ex_pkg::reg_idx_t b_reg,
  input  logic             a_reg_valid,
  input  logic             b_reg_valid,
  input  ex_pkg::fwd_src_t ex_mem,
  input  ex_pkg::fwd_src_t mem_wb,
  output ex_pkg::word_t    operand_a,
  output ex_pkg::word_t    operand_b_fwd
);
  import ex_pkg::*;

  logic  a_hit_ex;
  logic  a_hit_wb;
  logic  b_hit_ex;
  logic  b_hit_wb;
  logic  a_hit_ex_q;
  logic  a_hit_wb_q;
  logic  b_hit_ex_q;
  logic  b_hit_wb_q;
  word_t ex_mem_res_q;
  word_t mem_wb_res_q;
  logic  stall_q;
  logic  stall_rise;

  // ex_mem is the younger result and takes priority
  function automatic word_t pick(input word_t own, input logic hit_ex, input logic hit_wb,
                                 input word_t res_ex, input word_t res_wb);
    if (hit_ex)
      return res_ex;
    else if (hit_wb)
      return res_wb;
    return own;
  endfunction

  assign a_hit_ex = a_reg_valid && ex_mem.dest_valid && (a_reg == ex_mem.dest);
  assign a_hit_wb = a_reg_valid && mem_wb.dest_valid && (a_reg == mem_wb.dest);
  assign b_hit_ex = b_reg_valid && ex_mem.dest_valid && (b_reg == ex_mem.dest);
  assign b_hit_wb = b_reg_valid && mem_wb.dest_valid && (b_reg == mem_wb.dest);

  assign stall_rise = stall_active && !stall_q;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_q      <= 1'b0;
      a_hit_ex_q   <= 1'b0;
      a_hit_wb_q   <= 1'b0;
      b_hit_ex_q   <= 1'b0;
      b_hit_wb_q   <= 1'b0;
      ex_mem_res_q <= '0;
      mem_wb_res_q <= '0;
    end else begin
      stall_q <= stall_active;
      // Later stages may move on during the stall, so freeze what they offered
      if (stall_rise) begin
        a_hit_ex_q   <= a_hit_ex;
        a_hit_wb_q   <= a_hit_wb;
        b_hit_ex_q   <= b_hit_ex;
        b_hit_wb_q   <= b_hit_wb;
        ex_mem_res_q <= ex_mem.result;
        mem_wb_res_q <= mem_wb.result;
      end
    end
  end

  assign operand_a = stall_q ?
      pick(a_val, a_hit_ex_q, a_hit_wb_q, ex_mem_res_q, mem_wb_res_q) :
      pick(a_val, a_hit_ex, a_hit_wb, ex_mem.result, mem_wb.result);

  assign operand_b_fwd = stall_q ?
      pick(b_val, b_hit_ex_q, b_hit_wb_q, ex_mem_res_q, mem_wb_res_q) :
      pick(b_val, b_hit_ex, b_hit_wb, ex_mem.result, mem_wb.result);

endmodule

//--- design/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter (
  input  ex_pkg::word_t  operand,
  input  ex_pkg::shamt_t amount,
  input  logic           shleft,
  input  logic           sharith,
  output ex_pkg::word_t  shifted
);
  import ex_pkg::*;

  word_t stage;
  logic  fill;

  assign fill = sharith && operand[31];

  // One level per amount bit, shifting by 1, 2, 4, 8 and 16
  always_comb begin
    stage = operand;
    for (int i = 0; i < 5; i++) begin
      if (amount[i]) begin
        if (shleft)
          stage = stage << (1 << i);
        else
          stage = (stage >> (1 << i)) | ({32{fill}} << (32 - (1 << i)));
      end
    end
  end

  assign shifted = stage;

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
  input  ex_pkg::alu_op_t op,
  input  logic            set_u,
  input  ex_pkg::word_t   a,
  input  ex_pkg::word_t   b,
  input  ex_pkg::word_t   b_fwd,
  input  ex_pkg::word_t   shift_res,
  input  ex_pkg::word_t   imm,
  output ex_pkg::word_t   alu_res,
  output ex_pkg::word_t   set_res,
  output logic            inval_dest_reg
);
  import ex_pkg::*;

  word_t       sum;
  logic [32:0] diff;
  logic        signed_lt;
  shamt_t      ext_msbd;
  word_t       ext_mask;
  word_t       ins_mask;
  logic        b_zero;

  assign sum  = a + b;
  // Top bit is the borrow of the unsigned subtract
  assign diff = {1'b0, a} - {1'b0, b};

  // a negative and b not, or same signs and a negative difference
  assign signed_lt = (a[31] && !b[31]) || (diff[31] && !(a[31] ^ b[31]));
  assign set_res   = {31'b0, set_u ? diff[32] : signed_lt};

  // Field size lives in imm[15:11] as size minus one
  assign ext_msbd = imm[15:11];
  assign ext_mask = ~(32'hffff_fffe << ext_msbd);
  assign ins_mask = ext_mask >> 1;

  always_comb begin
    alu_res = '0;
    case (op)
      ADD:
        alu_res = sum;
      SUB:
        alu_res = diff[31:0];
      OR:
        alu_res = a | b;
      XOR:
        alu_res = a ^ b;
      NOR:
        alu_res = ~(a | b);
      AND:
        alu_res = a & b;
      PASS_A:
        alu_res = a;
      PASS_B:
        alu_res = b;
      LUI:
        alu_res = {b[15:0], 16'b0};
      MOVZ,
      MOVN:
        alu_res = a;
      SEB:
        alu_res = {{24{b[7]}}, b[7:0]};
      SEH:
        alu_res = {{16{b[15]}}, b[15:0]};
      EXT:
        alu_res = shift_res & ext_mask;
      INS:
        // b itself carries the immediate here, so merge into the register value
        alu_res = (shift_res & ins_mask) | (b_fwd & ~ins_mask);
      default:
        alu_res = '0;
    endcase
  end

  assign b_zero = (b == '0);

  always_comb begin
    case (op)
      MOVZ:    inval_dest_reg = !b_zero;
      MOVN:    inval_dest_reg = b_zero;
      default: inval_dest_reg = 1'b0;
    endcase
  end

endmodule

//--- design/muldiv_unit.sv
`timescale 1ns/1ps

module muldiv_unit #(
  parameter int MUL_CYCLES = 5,
  parameter int DIV_CYCLES = 35
) (
  input  logic               clock,
  input  logic               reset_n,
  input  ex_pkg::muldiv_op_t op,
  input  logic               is_unsigned,
  input  ex_pkg::word_t      a,
  input  ex_pkg::word_t      b,
  input  logic               front_stall,
  output ex_pkg::word_t      hi,
  output ex_pkg::word_t      lo,
  output logic               stall
);
  import ex_pkg::*;

  // Divide is the longest operation
  localparam int CNT_W = $clog2(DIV_CYCLES + 1);

  mdu_state_t       state;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] target;
  logic             multi_op;
  logic             done;
  logic [63:0]      product;
  logic [63:0]      next_hilo;

  assign multi_op = (op == MD_MUL) || (op == MD_MADD) || (op == MD_DIV);
  assign target   = (op == MD_DIV) ? CNT_W'(DIV_CYCLES) : CNT_W'(MUL_CYCLES);
  assign done     = (state == MDU_BUSY) && (count == target);
  assign stall    = multi_op ? !done : front_stall;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= MDU_IDLE;
      count <= '0;
    end else begin
      case (state)
        MDU_IDLE: begin
          if (multi_op) begin
            state <= MDU_BUSY;
            count <= CNT_W'(1);
          end
        end
        MDU_BUSY: begin
          if (done || !multi_op) begin
            state <= MDU_IDLE;
            count <= '0;
          end else begin
            count <= count + 1'b1;
          end
        end
        default: begin
          state <= MDU_IDLE;
          count <= '0;
        end
      endcase
    end
  end

  always_comb begin
    if (is_unsigned)
      product = {32'b0, a} * {32'b0, b};
    else
      product = $signed(a) * $signed(b);
    case (op)
      MD_MADD:
        next_hilo = {hi, lo} + product;
      MD_DIV:
        if (is_unsigned)
          next_hilo = {a % b, a / b};
        else
          next_hilo = {$signed(a) % $signed(b), $signed(a) / $signed(b)};
      default:
        next_hilo = product;
    endcase
  end

  // Remainder lands in hi, quotient in lo
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      hi <= '0;
      lo <= '0;
    end else if (done) begin
      {hi, lo} <= next_hilo;
    end else if (!stall && op == MD_MTHI) begin
      hi <= a;
    end else if (!stall && op == MD_MTLO) begin
      lo <= a;
    end
  end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
  parameter int MUL_CYCLES = 5,
  parameter int DIV_CYCLES = 35
) (
  input  logic             clock,
  input  logic             reset_n,
  input  ex_pkg::ex_ctrl_t ctrl,
  input  ex_pkg::word_t    a_val,
  input  ex_pkg::word_t    b_val,
  input  ex_pkg::reg_idx_t a_reg,
  input  logic             a_reg_valid,
  input  ex_pkg::reg_idx_t b_reg,
  input  logic             b_reg_valid,
  input  ex_pkg::word_t    imm,
  input  ex_pkg::fwd_src_t ex_mem,
  input  ex_pkg::fwd_src_t mem_wb,
  input  logic             front_stall,
  output ex_pkg::word_t    result,
  output ex_pkg::word_t    store_data,
  output logic             inval_dest_reg,
  output logic             stall
);
  import ex_pkg::*;

  word_t  operand_a;
  word_t  operand_b_fwd;
  word_t  operand_b;
  word_t  shift_operand;
  shamt_t shift_amount;
  word_t  shift_res;
  word_t  alu_res;
  word_t  set_res;
  word_t  hi;
  word_t  lo;

  operand_forward operand_forward_i (
    .clock         (clock),
    .reset_n       (reset_n),
    .stall_active  (stall),
    .a_val         (a_val),
    .b_val         (b_val),
    .a_reg         (a_reg),
    .b_reg         (b_reg),
    .a_reg_valid   (a_reg_valid),
    .b_reg_valid   (b_reg_valid),
    .ex_mem        (ex_mem),
    .mem_wb        (mem_wb),
    .operand_a     (operand_a),
    .operand_b_fwd (operand_b_fwd)
  );

  assign operand_b  = ctrl.imm_valid ? imm : operand_b_fwd;
  assign store_data = operand_b_fwd;

  // Variable shifts take their amount from rs
  assign shift_operand = ctrl.shopsela ? operand_a : operand_b;
  assign shift_amount  = ctrl.shamt_valid ? ctrl.shamt : operand_a[4:0];

  barrel_shifter barrel_shifter_i (
    .operand (shift_operand),
    .amount  (shift_amount),
    .shleft  (ctrl.shleft),
    .sharith (ctrl.sharith),
    .shifted (shift_res)
  );

  alu alu_i (
    .op             (ctrl.alu_op),
    .set_u          (ctrl.alu_set_u),
    .a              (operand_a),
    .b              (operand_b),
    .b_fwd          (operand_b_fwd),
    .shift_res      (shift_res),
    .imm            (imm),
    .alu_res        (alu_res),
    .set_res        (set_res),
    .inval_dest_reg (inval_dest_reg)
  );

  muldiv_unit #(
    .MUL_CYCLES (MUL_CYCLES),
    .DIV_CYCLES (DIV_CYCLES)
  ) muldiv_unit_i (
    .clock       (clock),
    .reset_n     (reset_n),
    .op          (ctrl.muldiv_op),
    .is_unsigned (ctrl.muldiv_u),
    .a           (operand_a),
    .b           (operand_b),
    .front_stall (front_stall),
    .hi          (hi),
    .lo          (lo),
    .stall       (stall)
  );

  always_comb begin
    if (ctrl.muldiv_op == MD_MFHI)
      result = hi;
    else if (ctrl.muldiv_op == MD_MFLO)
      result = lo;
    else begin
      case (ctrl.alu_res_sel)
        RES_SHIFT: result = shift_res;
        RES_SET:   result = set_res;
        default:   result = alu_res;
      endcase
    end
  end

endmodule

//--- verification/execute_stage_tb.sv
`timescale 1ns/1ps

module execute_stage_tb;
  import ex_pkg::*;

  localparam int MUL_CYCLES = 5;
  localparam int DIV_CYCLES = 35;

  // One table row: stimulus plus what the stage must answer
  typedef struct packed {
    ex_ctrl_t   ctrl;
    word_t      a_val;
    word_t      b_val;
    reg_idx_t   a_reg;
    logic       a_reg_valid;
    reg_idx_t   b_reg;
    logic       b_reg_valid;
    word_t      imm;
    fwd_src_t   ex_mem;
    fwd_src_t   mem_wb;
    logic       front_stall;
    word_t      exp_result;
    word_t      exp_store;
    logic       exp_inval;
    logic [7:0] exp_cycles;
  } entry_t;

  logic     clock;
  logic     reset_n;
  ex_ctrl_t ctrl;
  word_t    a_val;
  word_t    b_val;
  reg_idx_t a_reg;
  logic     a_reg_valid;
  reg_idx_t b_reg;
  logic     b_reg_valid;
  word_t    imm;
  fwd_src_t ex_mem;
  fwd_src_t mem_wb;
  logic     front_stall;
  word_t    result;
  word_t    store_data;
  logic     inval_dest_reg;
  logic     stall;

  entry_t table_q[$];
  string  name_q[$];
  integer seed = 58;
  word_t  ra;
  word_t  rb;
  word_t  ri;
  word_t  rx;
  word_t  rw;
  word_t  model_hi;
  word_t  model_lo;
  int     error_count = 0;
  int     check_count = 0;
  int     cycle_count = 0;
  int     cycle_limit = 1000000;

  execute_stage #(
    .MUL_CYCLES (MUL_CYCLES),
    .DIV_CYCLES (DIV_CYCLES)
  ) execute_stage_i (
    .clock          (clock),
    .reset_n        (reset_n),
    .ctrl           (ctrl),
    .a_val          (a_val),
    .b_val          (b_val),
    .a_reg          (a_reg),
    .a_reg_valid    (a_reg_valid),
    .b_reg          (b_reg),
    .b_reg_valid    (b_reg_valid),
    .imm            (imm),
    .ex_mem         (ex_mem),
    .mem_wb         (mem_wb),
    .front_stall    (front_stall),
    .result         (result),
    .store_data     (store_data),
    .inval_dest_reg (inval_dest_reg),
    .stall          (stall)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run stopped after %0d cycles before the table was done", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input string what, input word_t expected,
                             input word_t actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      $display("mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
    end
  endtask

  function automatic logic [63:0] product(input word_t a, input word_t b, input logic u);
    if (u)
      return {32'b0, a} * {32'b0, b};
    return {{32{a[31]}}, a} * {{32{b[31]}}, b};
  endfunction

  task automatic new_operands;
    ra = $random(seed);
    rb = $random(seed);
    ri = $random(seed);
    rx = $random(seed);
    rw = $random(seed);
  endtask

  task automatic push(input string name, input entry_t e);
    table_q.push_back(e);
    name_q.push_back(name);
  endtask

  task automatic alu_case(input string name, input alu_op_t op, input alu_res_t sel,
                          input logic set_u, input logic imm_valid, input word_t exp,
                          input logic exp_inval);
    entry_t e;
    e = '0;
    e.ctrl.alu_op = op;
    e.ctrl.alu_res_sel = sel;
    e.ctrl.alu_set_u = set_u;
    e.ctrl.imm_valid = imm_valid;
    e.a_val = ra;
    e.b_val = rb;
    e.imm = ri;
    e.exp_result = exp;
    e.exp_store = rb;
    e.exp_inval = exp_inval;
    push(name, e);
  endtask

  task automatic shift_case(input string name, input logic shleft, input logic sharith,
                            input logic shamt_valid, input shamt_t shamt, input word_t exp);
    entry_t e;
    e = '0;
    e.ctrl.alu_res_sel = RES_SHIFT;
    e.ctrl.shleft = shleft;
    e.ctrl.sharith = sharith;
    e.ctrl.shamt_valid = shamt_valid;
    e.ctrl.shamt = shamt;
    e.a_val = ra;
    e.b_val = rb;
    e.exp_result = exp;
    e.exp_store = rb;
    push(name, e);
  endtask

  // Field size minus one sits in imm[15:11], operand A is shifted by shamt
  task automatic field_case(input string name, input alu_op_t op, input logic shleft,
                            input shamt_t shamt, input logic [4:0] field, input word_t exp);
    entry_t e;
    e = '0;
    e.ctrl.alu_op = op;
    e.ctrl.imm_valid = 1'b1;
    e.ctrl.shopsela = 1'b1;
    e.ctrl.shamt_valid = 1'b1;
    e.ctrl.shamt = shamt;
    e.ctrl.shleft = shleft;
    e.imm = {16'h0, field, 11'h0};
    e.a_val = ra;
    e.b_val = rb;
    e.exp_result = exp;
    e.exp_store = rb;
    push(name, e);
  endtask

  task automatic fwd_case(input string name, input reg_idx_t a_r, input logic a_v,
                          input reg_idx_t b_r, input logic b_v, input reg_idx_t ex_dest,
                          input reg_idx_t wb_dest, input word_t exp_a, input word_t exp_b);
    entry_t e;
    e = '0;
    e.a_val = ra;
    e.b_val = rb;
    e.a_reg = a_r;
    e.a_reg_valid = a_v;
    e.b_reg = b_r;
    e.b_reg_valid = b_v;
    e.ex_mem = {rx, ex_dest, 1'b1};
    e.mem_wb = {rw, wb_dest, 1'b1};
    e.exp_result = exp_a + exp_b;
    e.exp_store = exp_b;
    push(name, e);
  endtask

  // With fwd_a the register file copy of A is stale and ex_mem holds the real one
  task automatic md_case(input string name, input muldiv_op_t op, input logic is_u,
                         input logic fwd_a);
    entry_t e;
    e = '0;
    e.ctrl.muldiv_op = op;
    e.ctrl.muldiv_u = is_u;
    e.a_val = fwd_a ? ~ra : ra;
    e.b_val = rb;
    if (fwd_a) begin
      e.a_reg = 5'd5;
      e.a_reg_valid = 1'b1;
      e.ex_mem = {ra, 5'd5, 1'b1};
    end
    e.exp_cycles = (op == MD_DIV) ? 8'(DIV_CYCLES) : 8'(MUL_CYCLES);
    push(name, e);
  endtask

  task automatic move_case(input string name, input muldiv_op_t op);
    entry_t e;
    e = '0;
    e.ctrl.alu_op = PASS_A;
    e.ctrl.muldiv_op = op;
    e.a_val = ra;
    e.b_val = rb;
    e.exp_result = ra;
    e.exp_store = rb;
    push(name, e);
  endtask

  task automatic readback(input string name);
    entry_t e;
    e = '0;
    e.ctrl.muldiv_op = MD_MFHI;
    e.exp_result = model_hi;
    push({name, "_hi"}, e);
    e.ctrl.muldiv_op = MD_MFLO;
    e.exp_result = model_lo;
    push({name, "_lo"}, e);
  endtask

  task automatic build_table;
    entry_t e;
    repeat (3) begin
      new_operands();
      alu_case("add", ADD, RES_ALU, 1'b0, 1'b0, ra + rb, 1'b0);
      alu_case("sub", SUB, RES_ALU, 1'b0, 1'b0, ra - rb, 1'b0);
      alu_case("and", AND, RES_ALU, 1'b0, 1'b0, ra & rb, 1'b0);
      alu_case("or", OR, RES_ALU, 1'b0, 1'b0, ra | rb, 1'b0);
      alu_case("xor", XOR, RES_ALU, 1'b0, 1'b0, ra ^ rb, 1'b0);
      alu_case("nor", NOR, RES_ALU, 1'b0, 1'b0, ~(ra | rb), 1'b0);
      alu_case("addi", ADD, RES_ALU, 1'b0, 1'b1, ra + ri, 1'b0);
      alu_case("lui", LUI, RES_ALU, 1'b0, 1'b1, {ri[15:0], 16'h0}, 1'b0);
      alu_case("seb", SEB, RES_ALU, 1'b0, 1'b0, {{24{rb[7]}}, rb[7:0]}, 1'b0);
      alu_case("seh", SEH, RES_ALU, 1'b0, 1'b0, {{16{rb[15]}}, rb[15:0]}, 1'b0);
      alu_case("slt", ADD, RES_SET, 1'b0, 1'b0, {31'b0, $signed(ra) < $signed(rb)}, 1'b0);
      alu_case("sltu", ADD, RES_SET, 1'b1, 1'b0, {31'b0, ra < rb}, 1'b0);
      alu_case("slti", ADD, RES_SET, 1'b0, 1'b1, {31'b0, $signed(ra) < $signed(ri)}, 1'b0);
    end

    new_operands();
    rb[31] = 1'b1;
    shift_case("sll", 1'b1, 1'b0, 1'b1, 5'd7, rb << 7);
    shift_case("srl", 1'b0, 1'b0, 1'b1, 5'd13, rb >> 13);
    shift_case("sra", 1'b0, 1'b1, 1'b1, 5'd20, $signed(rb) >>> 20);
    shift_case("sllv", 1'b1, 1'b0, 1'b0, 5'd0, rb << ra[4:0]);
    shift_case("srlv", 1'b0, 1'b0, 1'b0, 5'd0, rb >> ra[4:0]);
    shift_case("srav", 1'b0, 1'b1, 1'b0, 5'd0, $signed(rb) >>> ra[4:0]);
    field_case("ext_8_8", EXT, 1'b0, 5'd8, 5'd7, (ra >> 8) & 32'h0000_00ff);
    field_case("ext_3_20", EXT, 1'b0, 5'd3, 5'd19, (ra >> 3) & 32'h000f_ffff);
    field_case("ext_0_32", EXT, 1'b0, 5'd0, 5'd31, ra);
    field_case("ins_12", INS, 1'b1, 5'd4, 5'd12, ((ra << 4) & 32'hfff) | (rb & ~32'hfff));
    field_case("ins_16", INS, 1'b1, 5'd0, 5'd16, (ra & 32'hffff) | (rb & 32'hffff_0000));

    new_operands();
    fwd_case("fwd_ex_over_wb", 5'd5, 1'b1, 5'd6, 1'b1, 5'd5, 5'd5, rx, rb);
    fwd_case("fwd_wb_only", 5'd8, 1'b1, 5'd9, 1'b1, 5'd4, 5'd9, ra, rw);
    fwd_case("fwd_ex_both", 5'd3, 1'b1, 5'd3, 1'b1, 5'd3, 5'd7, rx, rx);
    fwd_case("fwd_none", 5'd1, 1'b1, 5'd2, 1'b1, 5'd3, 5'd4, ra, rb);
    fwd_case("fwd_src_invalid", 5'd5, 1'b0, 5'd5, 1'b0, 5'd5, 5'd5, ra, rb);

    new_operands();
    {model_hi, model_lo} = product(ra, rb, 1'b0);
    md_case("mult", MD_MUL, 1'b0, 1'b0);
    readback("mult");
    new_operands();
    {model_hi, model_lo} = product(ra, rb, 1'b1);
    md_case("multu", MD_MUL, 1'b1, 1'b0);
    readback("multu");
    new_operands();
    {model_hi, model_lo} = {model_hi, model_lo} + product(ra, rb, 1'b0);
    md_case("madd", MD_MADD, 1'b0, 1'b0);
    readback("madd");
    new_operands();
    if (rb == '0)
      rb = 32'd7;
    model_lo = $signed(ra) / $signed(rb);
    model_hi = $signed(ra) % $signed(rb);
    md_case("div", MD_DIV, 1'b0, 1'b0);
    readback("div");
    // Quotient truncates toward zero, remainder takes the dividend's sign
    ra = 32'hffff_fff9;
    rb = 32'd2;
    model_lo = 32'hffff_fffd;
    model_hi = 32'hffff_ffff;
    md_case("div_neg", MD_DIV, 1'b0, 1'b0);
    readback("div_neg");
    new_operands();
    rb[0] = 1'b1;
    model_lo = ra / rb;
    model_hi = ra % rb;
    md_case("divu", MD_DIV, 1'b1, 1'b0);
    readback("divu");
    new_operands();
    model_hi = ra;
    move_case("mthi", MD_MTHI);
    new_operands();
    model_lo = ra;
    move_case("mtlo", MD_MTLO);
    readback("mthi_mtlo");
    new_operands();
    {model_hi, model_lo} = product(ra, rb, 1'b1);
    md_case("multu_fwd", MD_MUL, 1'b1, 1'b1);
    readback("multu_fwd");

    new_operands();
    e = '0;
    e.ctrl.alu_op = OR;
    e.a_val = ra;
    e.b_val = rb;
    e.front_stall = 1'b1;
    e.exp_result = ra | rb;
    e.exp_store = rb;
    push("front_stall", e);
    // The same instruction stays presented until stall drops
    e.front_stall = 1'b0;
    push("front_stall_release", e);
    rb[0] = 1'b1;
    alu_case("movz_nonzero", MOVZ, RES_ALU, 1'b0, 1'b0, ra, 1'b1);
    alu_case("movn_nonzero", MOVN, RES_ALU, 1'b0, 1'b0, ra, 1'b0);
    rb = '0;
    alu_case("movz_zero", MOVZ, RES_ALU, 1'b0, 1'b0, ra, 1'b0);
    alu_case("movn_zero", MOVN, RES_ALU, 1'b0, 1'b0, ra, 1'b1);
  endtask

  task automatic apply(input entry_t e);
    ctrl        <= e.ctrl;
    a_val       <= e.a_val;
    b_val       <= e.b_val;
    a_reg       <= e.a_reg;
    a_reg_valid <= e.a_reg_valid;
    b_reg       <= e.b_reg;
    b_reg_valid <= e.b_reg_valid;
    imm         <= e.imm;
    ex_mem      <= e.ex_mem;
    mem_wb      <= e.mem_wb;
    front_stall <= e.front_stall;
  endtask

  initial begin
    entry_t cur;
    int     stall_cycles;
    reset_n = 1'b0;
    ctrl = '0;
    a_val = '0;
    b_val = '0;
    a_reg = '0;
    a_reg_valid = 1'b0;
    b_reg = '0;
    b_reg_valid = 1'b0;
    imm = '0;
    ex_mem = '0;
    mem_wb = '0;
    front_stall = 1'b0;
    build_table();
    cycle_limit = table_q.size() * (DIV_CYCLES + 4) + 16 + 100;
    repeat (16) @(posedge clock);
    reset_n <= 1'b1;

    foreach (table_q[i]) begin
      cur = table_q[i];
      @(posedge clock);
      apply(cur);
      @(negedge clock);
      if (cur.exp_cycles == 0) begin
        check_value(name_q[i], "result", cur.exp_result, result);
        check_value(name_q[i], "store_data", cur.exp_store, store_data);
        check_value(name_q[i], "inval_dest_reg", cur.exp_inval, inval_dest_reg);
        check_value(name_q[i], "stall", cur.front_stall, stall);
      end else begin
        stall_cycles = 0;
        while (stall) begin
          stall_cycles++;
          @(posedge clock);
          // Later stages move on, the operands captured in cycle one must hold
          if (stall_cycles == 1) begin
            ex_mem.result <= ~ex_mem.result;
            mem_wb.result <= ~mem_wb.result;
          end
          @(negedge clock);
        end
        check_value(name_q[i], "stall_cycles", cur.exp_cycles, stall_cycles);
      end
    end

    @(posedge clock);
    $display("errors: %0d of %0d checks", error_count, check_count);
    if (error_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- project.f
design/ex_pkg.sv
design/operand_forward.sv
design/barrel_shifter.sv
design/alu.sv
design/muldiv_unit.sv
design/execute_stage.sv
verification/execute_stage_tb.sv
